// File: common/fis_rx_pkg.sv
package fis_rx_pkg;

    typedef enum logic [2:0] {
        FIS_DSFIS,   // dma setup
        FIS_PSFIS,   // pio setup
        FIS_RFIS,    // register d2h
        FIS_SDBFIS,  // set device bits
        FIS_UFIS,    // unknown fis, stored as is
        FIS_DATA,    // data fis, payload goes to dma
        FIS_IGNORE   // consume and drop
    } fis_cmd_e;

    typedef enum logic [1:0] {
        WT_DATA,  // payload dword
        WT_HEAD,  // first dword of a fis
        WT_OK,    // end, crc good
        WT_ERR    // end, crc bad
    } word_type_e;

    localparam int ADDRESS_BITS_DEF = 10;

    localparam int FB_OFFS32    = 'h300;  // received-fis area, 0x100 bytes
    localparam int DSFIS32      = 'h0;
    localparam int PSFIS32      = 'h8;
    localparam int RFIS32       = 'h10;
    localparam int SDBFIS32     = 'h16;
    localparam int UFIS32       = 'h18;
    localparam int PXTFD_OFFS32 = 'h48;   // port 0 task file data

    // dwords kept for each fis type, minus one
    function automatic logic [3:0] fis_lenm1(fis_cmd_e cmd);
        case (cmd)
            FIS_DSFIS:  return 4'd6;
            FIS_PSFIS,
            FIS_RFIS:   return 4'd4;
            FIS_SDBFIS: return 4'd1;
            FIS_DATA:   return 4'd0;   // only the header dword
            default:    return 4'd15;  // unknown and ignored
        endcase
    endfunction

    function automatic logic [ADDRESS_BITS_DEF-1:0] fis_base(fis_cmd_e cmd);
        int offs;
        case (cmd)
            FIS_DSFIS:  offs = DSFIS32;
            FIS_PSFIS:  offs = PSFIS32;
            FIS_RFIS:   offs = RFIS32;
            FIS_SDBFIS: offs = SDBFIS32;
            default:    offs = UFIS32;  // data/ignore never write
        endcase
        return ADDRESS_BITS_DEF'(FB_OFFS32 + offs);
    endfunction

endpackage

// File: fis_rx/ahci_fis_receive.sv
module ahci_fis_receive #(
    parameter int ADDRESS_BITS  = fis_rx_pkg::ADDRESS_BITS_DEF,
    parameter int DATA_CNT_BITS = 12
) (
    input  logic                     mclk,
    input  logic                     hba_rst,
    input  logic [31:0]              hba_data_in,
    input  fis_rx_pkg::word_type_e   hba_data_in_type,
    input  logic                     hba_data_in_valid,
    output logic                     hba_data_in_ready,
    input  fis_rx_pkg::fis_cmd_e     fis_cmd,
    input  logic                     fis_cmd_valid,
    output logic                     fis_first_vld,
    output logic                     get_fis_busy,
    output logic                     get_fis_done,
    output logic                     fis_ok,
    output logic                     fis_err,
    output logic                     fis_ferr,
    input  logic                     pcmd_fre,
    input  logic                     update_err_sts,
    input  logic                     clear_bsy_drq,
    input  logic                     clear_bsy_set_drq,
    input  logic                     set_bsy,
    output logic [7:0]               tfd_sts,
    output logic [7:0]               tfd_err,
    output logic [DATA_CNT_BITS-1:0] data_in_dwords,
    input  logic                     dma_in_ready,
    output logic                     dma_in_valid,
    output logic [ADDRESS_BITS-1:0]  reg_addr,
    output logic [31:0]              reg_data,
    output logic                     reg_we
);
    import fis_rx_pkg::*;

    logic                    word_take;
    word_type_e              word_type_q;
    logic [31:0]             data_q;
    logic                    fis_run;
    logic                    take_payload;
    logic                    store_we;
    logic [ADDRESS_BITS-1:0] store_addr;
    logic [3:0]              payload_idx;
    fis_cmd_e                cmd_q;
    logic                    dwords_over;
    logic                    too_long_store;
    logic                    too_long_dma;
    logic                    tfd_wr_req;

    fis_intake i_fis_intake (
        .mclk(mclk), .hba_rst(hba_rst),
        .hba_data_in(hba_data_in), .hba_data_in_type(hba_data_in_type),
        .hba_data_in_valid(hba_data_in_valid), .hba_data_in_ready(hba_data_in_ready),
        .fis_cmd_valid(fis_cmd_valid), .take_payload(take_payload),
        .too_long_store(too_long_store), .too_long_dma(too_long_dma),
        .word_take(word_take), .word_type_q(word_type_q), .data_q(data_q),
        .fis_run(fis_run), .fis_first_vld(fis_first_vld),
        .get_fis_busy(get_fis_busy), .get_fis_done(get_fis_done),
        .fis_ok(fis_ok), .fis_err(fis_err), .fis_ferr(fis_ferr)
    );

    fis_store_seq #(.ADDRESS_BITS(ADDRESS_BITS)) i_fis_store_seq (
        .mclk(mclk), .hba_rst(hba_rst),
        .fis_cmd_valid(fis_cmd_valid), .fis_cmd(fis_cmd), .pcmd_fre(pcmd_fre),
        .word_take(word_take), .word_type_q(word_type_q),
        .store_we(store_we), .store_addr(store_addr), .payload_idx(payload_idx),
        .cmd_q(cmd_q), .dwords_over(dwords_over), .too_long_store(too_long_store)
    );

    dma_forward #(.DATA_CNT_BITS(DATA_CNT_BITS)) i_dma_forward (
        .mclk(mclk), .hba_rst(hba_rst), .cmd_q(cmd_q), .fis_run(fis_run),
        .hba_data_in_valid(hba_data_in_valid), .hba_data_in_type(hba_data_in_type),
        .dma_in_ready(dma_in_ready), .store_done(dwords_over),
        .take_payload(take_payload), .dma_in_valid(dma_in_valid),
        .data_in_dwords(data_in_dwords), .too_long_dma(too_long_dma)
    );

    tfd_status i_tfd_status (
        .mclk(mclk), .hba_rst(hba_rst),
        .store_we(store_we), .cmd_q(cmd_q), .payload_idx(payload_idx),
        .hba_data_in(data_q), .update_err_sts(update_err_sts),
        .clear_bsy_drq(clear_bsy_drq), .clear_bsy_set_drq(clear_bsy_set_drq),
        .set_bsy(set_bsy),
        .tfd_sts(tfd_sts), .tfd_err(tfd_err), .tfd_wr_req(tfd_wr_req)
    );

    reg_write_mux #(.ADDRESS_BITS(ADDRESS_BITS)) i_reg_write_mux (
        .mclk(mclk), .hba_rst(hba_rst),
        .store_we(store_we), .store_addr(store_addr), .store_data(data_q),
        .tfd_wr_req(tfd_wr_req), .tfd_sts(tfd_sts), .tfd_err(tfd_err),
        .reg_addr(reg_addr), .reg_data(reg_data), .reg_we(reg_we)
    );

endmodule

// File: fis_rx/dma_forward.sv
module dma_forward #(
    parameter int DATA_CNT_BITS = 12
) (
    input  logic                     mclk,
    input  logic                     hba_rst,
    input  fis_rx_pkg::fis_cmd_e     cmd_q,
    input  logic                     fis_run,
    input  logic                     hba_data_in_valid,
    input  fis_rx_pkg::word_type_e   hba_data_in_type,
    input  logic                     dma_in_ready,
    input  logic                     store_done,     // header dword went through stage 2
    output logic                     take_payload,
    output logic                     dma_in_valid,
    output logic [DATA_CNT_BITS-1:0] data_in_dwords,
    output logic                     too_long_dma
);
    import fis_rx_pkg::*;

    logic is_data_fis;
    logic is_payload;
    logic dma_in;       // forwarding window open
    logic dma_started;  // window opened once for this fis
    logic dma_start;
    logic dma_stop;

    assign is_data_fis = cmd_q == FIS_DATA;
    assign is_payload  = hba_data_in_type == WT_DATA;
    assign dma_start   = fis_run && is_data_fis && store_done && !dma_started;
    assign dma_stop    = dma_in && hba_data_in_valid && !is_payload;  // any non-data word
    assign dma_in_valid = dma_in && fis_run && hba_data_in_valid && is_payload &&
                          dma_in_ready && !too_long_dma;

    always_comb begin
        if (!is_data_fis)
            take_payload = 1'b1;  // stored fis words never stall
        else if (dma_in)
            take_payload = !is_payload || dma_in_ready || too_long_dma;  // drop after fatal
        else
            take_payload = hba_data_in_type == WT_HEAD && !store_done;  // header only
    end

    always_ff @(posedge mclk) begin
        if (hba_rst || !fis_run) begin
            dma_in      <= 1'b0;
            dma_started <= 1'b0;
        end else if (dma_start) begin
            dma_in      <= 1'b1;
            dma_started <= 1'b1;
        end else if (dma_stop) begin
            dma_in      <= 1'b0;
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            data_in_dwords <= '0;
            too_long_dma   <= 1'b0;
        end else begin
            if (dma_start)
                data_in_dwords <= '0;
            else if (dma_in_valid)
                data_in_dwords <= data_in_dwords + 1'b1;  // held after done for the reader

            if (dma_in_valid && data_in_dwords[DATA_CNT_BITS-1])
                too_long_dma <= 1'b1;  // fatal, only reset clears
        end
    end

endmodule

// File: fis_rx/fis_intake.sv
module fis_intake (
    input  logic                   mclk,
    input  logic                   hba_rst,
    input  logic [31:0]            hba_data_in,
    input  fis_rx_pkg::word_type_e hba_data_in_type,
    input  logic                   hba_data_in_valid,
    output logic                   hba_data_in_ready,
    input  logic                   fis_cmd_valid,
    input  logic                   take_payload,    // downstream can take a non-end word
    input  logic                   too_long_store,
    input  logic                   too_long_dma,
    output logic                   word_take,       // word accepted last cycle
    output fis_rx_pkg::word_type_e word_type_q,
    output logic [31:0]            data_q,
    output logic                   fis_run,
    output logic                   fis_first_vld,
    output logic                   get_fis_busy,
    output logic                   get_fis_done,
    output logic                   fis_ok,
    output logic                   fis_err,
    output logic                   fis_ferr
);
    import fis_rx_pkg::*;

    logic is_end;
    logic accept;
    logic fis_end;

    assign is_end            = hba_data_in_type == WT_OK || hba_data_in_type == WT_ERR;
    assign hba_data_in_ready = fis_run && (is_end || take_payload);  // end words always taken
    assign accept            = hba_data_in_valid && hba_data_in_ready;
    assign fis_end           = accept && is_end;
    assign fis_ferr          = too_long_store || too_long_dma;  // both sticky until reset

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            fis_run       <= 1'b0;
            get_fis_busy  <= 1'b0;
            get_fis_done  <= 1'b0;
            fis_ok        <= 1'b0;
            fis_err       <= 1'b0;
            fis_first_vld <= 1'b0;
            word_take     <= 1'b0;
        end else begin
            word_take <= accept;

            if (fis_cmd_valid)
                fis_run <= 1'b1;
            else if (fis_end)
                fis_run <= 1'b0;  // runs to the end word even after fatal

            if (fis_cmd_valid)
                get_fis_busy <= 1'b1;
            else if (fis_end || fis_ferr)
                get_fis_busy <= 1'b0;

            get_fis_done <= get_fis_busy && (fis_end || fis_ferr);

            if (fis_cmd_valid) begin
                fis_ok  <= 1'b0;
                fis_err <= 1'b0;
            end else if (fis_end) begin
                fis_ok  <= hba_data_in_type == WT_OK;
                fis_err <= hba_data_in_type == WT_ERR;
            end

            // head waiting at the stream output while idle
            if (fis_cmd_valid || fis_run || get_fis_busy)
                fis_first_vld <= 1'b0;
            else if (hba_data_in_valid && hba_data_in_type == WT_HEAD)
                fis_first_vld <= 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (accept) begin
            word_type_q <= hba_data_in_type;
            data_q      <= hba_data_in;
        end
    end

endmodule

// File: fis_rx/fis_store_seq.sv
module fis_store_seq #(
    parameter int ADDRESS_BITS = fis_rx_pkg::ADDRESS_BITS_DEF
) (
    input  logic                    mclk,
    input  logic                    hba_rst,
    input  logic                    fis_cmd_valid,
    input  fis_rx_pkg::fis_cmd_e    fis_cmd,
    input  logic                    pcmd_fre,
    input  logic                    word_take,
    input  fis_rx_pkg::word_type_e  word_type_q,
    output logic                    store_we,
    output logic [ADDRESS_BITS-1:0] store_addr,
    output logic [3:0]              payload_idx,  // index of the word now in stage 2
    output fis_rx_pkg::fis_cmd_e    cmd_q,
    output logic                    dwords_over,  // all wanted dwords seen
    output logic                    too_long_store
);
    import fis_rx_pkg::*;

    logic [3:0] dcount;  // dwords left minus one
    logic       fis_save;
    logic       body_word;
    logic       step;
    logic       fixed_len;

    assign body_word = word_take && (word_type_q == WT_HEAD || word_type_q == WT_DATA);
    assign step      = body_word && !dwords_over;
    assign fixed_len = cmd_q != FIS_DATA && cmd_q != FIS_IGNORE;  // length known up front
    assign store_we  = step && fis_save;

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            cmd_q          <= FIS_IGNORE;
            fis_save       <= 1'b0;
            dwords_over    <= 1'b0;
            too_long_store <= 1'b0;
        end else begin
            if (fis_cmd_valid) begin
                cmd_q    <= fis_cmd;
                fis_save <= pcmd_fre && fis_cmd != FIS_DATA && fis_cmd != FIS_IGNORE;
            end

            if (fis_cmd_valid)
                dwords_over <= 1'b0;
            else if (step && dcount == 4'd0)
                dwords_over <= 1'b1;

            if (body_word && dwords_over && fixed_len)
                too_long_store <= 1'b1;  // one word past the stored length is fatal
        end
    end

    always_ff @(posedge mclk) begin
        if (fis_cmd_valid) begin
            store_addr  <= ADDRESS_BITS'(fis_base(fis_cmd));
            dcount      <= fis_lenm1(fis_cmd);
            payload_idx <= 4'd0;
        end else if (step) begin
            store_addr  <= store_addr + 1'b1;
            dcount      <= dcount - 1'b1;
            payload_idx <= payload_idx + 1'b1;
        end
    end

endmodule

// File: logic/reg_write_mux.sv
module reg_write_mux #(
    parameter int ADDRESS_BITS = fis_rx_pkg::ADDRESS_BITS_DEF
) (
    input  logic                    mclk,
    input  logic                    hba_rst,
    input  logic                    store_we,
    input  logic [ADDRESS_BITS-1:0] store_addr,
    input  logic [31:0]             store_data,
    input  logic                    tfd_wr_req,
    input  logic [7:0]              tfd_sts,
    input  logic [7:0]              tfd_err,
    output logic [ADDRESS_BITS-1:0] reg_addr,
    output logic [31:0]             reg_data,
    output logic                    reg_we
);
    import fis_rx_pkg::*;

    logic tfd_pend;  // pxtfd write lost to a fis store
    logic tfd_go;

    assign tfd_go = tfd_wr_req || tfd_pend;

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            reg_we   <= 1'b0;
            tfd_pend <= 1'b0;
        end else begin
            reg_we   <= store_we || tfd_go;
            tfd_pend <= tfd_go && store_we;
        end
    end

    always_ff @(posedge mclk) begin
        if (store_we) begin
            reg_addr <= store_addr;
            reg_data <= store_data;
        end else if (tfd_go) begin
            reg_addr <= ADDRESS_BITS'(PXTFD_OFFS32);
            reg_data <= {16'h0000, tfd_err, tfd_sts};  // value at send time
        end
    end

endmodule

// File: logic/tfd_status.sv
module tfd_status (
    input  logic                 mclk,
    input  logic                 hba_rst,
    input  logic                 store_we,
    input  fis_rx_pkg::fis_cmd_e cmd_q,
    input  logic [3:0]           payload_idx,
    input  logic [31:0]          hba_data_in,   // registered stream word
    input  logic                 update_err_sts,
    input  logic                 clear_bsy_drq,
    input  logic                 clear_bsy_set_drq,
    input  logic                 set_bsy,
    output logic [7:0]           tfd_sts,       // [7] bsy, [3] drq, [0] err
    output logic [7:0]           tfd_err,
    output logic                 tfd_wr_req
);
    import fis_rx_pkg::*;

    logic       first_word;
    logic       cap_reg;  // register d2h or pio setup, word 0
    logic       cap_sdb;
    logic       sts_cmd;
    logic [7:0] clr_mask;
    logic [7:0] set_mask;

    assign first_word = store_we && payload_idx == 4'd0;
    assign cap_reg    = first_word && (cmd_q == FIS_RFIS || cmd_q == FIS_PSFIS);
    assign cap_sdb    = first_word && cmd_q == FIS_SDBFIS;
    assign sts_cmd    = clear_bsy_drq || clear_bsy_set_drq || set_bsy;
    assign clr_mask   = {clear_bsy_drq || clear_bsy_set_drq, 3'b000, clear_bsy_drq, 3'b000};
    assign set_mask   = {set_bsy, 3'b000, clear_bsy_set_drq, 3'b000};

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            tfd_sts    <= 8'h00;
            tfd_err    <= 8'h00;
            tfd_wr_req <= 1'b0;
        end else begin
            tfd_wr_req <= update_err_sts || sts_cmd;  // write back next cycle

            if (cap_reg) begin
                tfd_err <= hba_data_in[31:24];
                tfd_sts <= hba_data_in[23:16];
            end else if (cap_sdb) begin
                tfd_err <= hba_data_in[15:8];
                tfd_sts <= {tfd_sts[7], hba_data_in[6:4], tfd_sts[3], hba_data_in[2:0]};  // bsy/drq kept
            end else if (sts_cmd) begin
                tfd_sts <= (tfd_sts & ~clr_mask) | set_mask;
            end
        end
    end

endmodule

// File: project.f
+incdir+tests
common/fis_rx_pkg.sv
fis_rx/fis_intake.sv
fis_rx/fis_store_seq.sv
fis_rx/dma_forward.sv
logic/tfd_status.sv
logic/reg_write_mux.sv
fis_rx/ahci_fis_receive.sv
tests/tb_ahci_fis_receive.sv

// File: run.sh
#!/bin/sh
# build and run the fis receive testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f project.f \
        --top-module tb_ahci_fis_receive --Mdir obj_dir -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^=== PASS ===$"; then
    exit 0
fi
echo "pass message not found"
exit 1

// File: tests/fis_rx_model.svh
`ifndef FIS_RX_MODEL_SVH
`define FIS_RX_MODEL_SVH

logic [7:0]  m_sts;       // predicted pxtfd status
logic [7:0]  m_err;       // predicted pxtfd error
logic [31:0] exp_addr[$]; // predicted register writes in order
logic [31:0] exp_data[$];

// word address where each stored fis type starts in the received-fis area
function automatic int area_base(fis_cmd_e cmd);
    case (cmd)
        FIS_DSFIS:  return 'h300;
        FIS_PSFIS:  return 'h308;
        FIS_RFIS:   return 'h310;
        FIS_SDBFIS: return 'h316;
        default:    return 'h318;
    endcase
endfunction

function automatic int stored_len(fis_cmd_e cmd);
    case (cmd)
        FIS_DSFIS:           return 7;
        FIS_PSFIS, FIS_RFIS: return 5;
        FIS_SDBFIS:          return 2;
        default:             return 16;
    endcase
endfunction

task automatic predict_fis(input fis_cmd_e cmd, input logic fre);
    int          n;
    logic [31:0] w;
    n = body_words.size() < stored_len(cmd) ? body_words.size() : stored_len(cmd);
    w = body_words[0];
    if (fre && cmd != FIS_DATA) begin
        for (int i = 0; i < n; i++) begin
            exp_addr.push_back(area_base(cmd) + i);
            exp_data.push_back(body_words[i]);
        end
        if (cmd == FIS_RFIS || cmd == FIS_PSFIS) begin
            m_err = w[31:24];
            m_sts = w[23:16];
        end else if (cmd == FIS_SDBFIS) begin
            m_err = w[15:8];
            m_sts = (m_sts & 8'h88) | (w[7:0] & 8'h77);  // bsy and drq stay
        end
    end
endtask

// kind 0 update only, 1 clear bsy/drq, 2 clear bsy set drq, 3 set bsy
task automatic predict_status_cmd(input int kind);
    case (kind)
        1: m_sts = m_sts & 8'h77;
        2: m_sts = (m_sts & 8'h7f) | 8'h08;
        3: m_sts = m_sts | 8'h80;
        default: ;
    endcase
    exp_addr.push_back('h48);
    exp_data.push_back({16'h0000, m_err, m_sts});
endtask

task automatic clear_model();
    m_sts = 8'h00;
    m_err = 8'h00;
    exp_addr.delete();
    exp_data.delete();
endtask

`endif

// File: tests/tb_ahci_fis_receive.sv
module tb_ahci_fis_receive;
    import fis_rx_pkg::*;

    localparam int TIMEOUT = 500;  // cycles per wait

    logic        mclk;
    logic        hba_rst;
    logic [31:0] hba_data_in;
    word_type_e  hba_data_in_type;
    logic        hba_data_in_valid;
    logic        hba_data_in_ready;
    fis_cmd_e    fis_cmd;
    logic        fis_cmd_valid;
    logic        fis_first_vld;
    logic        get_fis_busy;
    logic        get_fis_done;
    logic        fis_ok;
    logic        fis_err;
    logic        fis_ferr;
    logic        pcmd_fre;
    logic        update_err_sts;
    logic        clear_bsy_drq;
    logic        clear_bsy_set_drq;
    logic        set_bsy;
    logic [7:0]  tfd_sts;
    logic [7:0]  tfd_err;
    logic [11:0] data_in_dwords;
    logic        dma_in_ready;
    logic        dma_in_valid;
    logic [9:0]  reg_addr;
    logic [31:0] reg_data;
    logic        reg_we;

    integer      seed = 32'h7360_c5e9;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          done_cnt;
    int          end_gap;      // idle cycles before the end word
    logic        done_ok;      // fis_ok seen with get_fis_done
    logic        done_err;
    logic        end_busy;     // get_fis_busy when the end word was taken
    logic        dma_rand;     // random dma_in_ready while set
    logic [31:0] body_words[$];  // head plus payload of the next fis
    logic [31:0] seen_addr[$];
    logic [31:0] seen_data[$];
    logic [31:0] dma_seen[$];
    fis_cmd_e    stored_kinds[5] = '{FIS_DSFIS, FIS_PSFIS, FIS_RFIS, FIS_SDBFIS, FIS_UFIS};

    `include "fis_rx_model.svh"

    ahci_fis_receive i_ahci_fis_receive (.*);

    initial begin
        mclk = 1'b0;
        forever #10 mclk = ~mclk;
    end

    always @(posedge mclk) begin
        if (!hba_rst && reg_we) begin
            seen_addr.push_back(32'(reg_addr));
            seen_data.push_back(reg_data);
        end
        if (!hba_rst && dma_in_valid)
            dma_seen.push_back(hba_data_in);  // word moves to dma this edge
        if (!hba_rst && hba_data_in_valid && hba_data_in_ready &&
            (hba_data_in_type == WT_OK || hba_data_in_type == WT_ERR))
            end_busy = get_fis_busy;
        if (!hba_rst && get_fis_done) begin
            done_cnt++;
            done_ok  = fis_ok;
            done_err = fis_err;
        end
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic shake_ready();
        if (dma_rand)
            dma_in_ready = ($random(seed) & 3) != 0;  // ready about 3 of 4 cycles
    endtask

    task automatic wait_accept();
        int cnt;
        bit taken;
        cnt   = 0;
        taken = 1'b0;
        while (!taken && cnt < TIMEOUT) begin
            @(posedge mclk);
            taken = hba_data_in_ready;  // valid is held high here
            cnt++;
            if (!taken) begin
                @(negedge mclk);
                shake_ready();
            end
        end
        assert (taken) else begin
            $display("timeout, stream word was never accepted");
            errors++;
        end
    endtask

    task automatic make_body(input int count);
        body_words.delete();
        repeat (count) body_words.push_back($random(seed));
    endtask

    task automatic run_fis(input fis_cmd_e cmd, input logic fre, input word_type_e end_type);
        int cnt;
        int start;
        start = done_cnt;
        predict_fis(cmd, fre);
        @(negedge mclk);
        pcmd_fre          = fre;
        hba_data_in       = body_words[0];
        hba_data_in_type  = WT_HEAD;
        hba_data_in_valid = 1'b1;
        shake_ready();
        cnt = 0;
        while (!fis_first_vld && cnt < TIMEOUT) begin
            @(posedge mclk);
            cnt++;
        end
        assert (fis_first_vld) else begin
            $display("timeout, fis_first_vld never rose for a waiting head");
            errors++;
        end
        @(negedge mclk);
        fis_cmd       = cmd;
        fis_cmd_valid = 1'b1;
        @(negedge mclk);
        fis_cmd_valid = 1'b0;
        wait_accept();
        for (int i = 1; i < body_words.size(); i++) begin
            @(negedge mclk);
            hba_data_in      = body_words[i];
            hba_data_in_type = WT_DATA;
            shake_ready();
            wait_accept();
        end
        if (end_gap > 0) begin
            @(negedge mclk);
            hba_data_in_valid = 1'b0;
            repeat (end_gap - 1) @(negedge mclk);
        end
        @(negedge mclk);
        hba_data_in_type  = end_type;
        hba_data_in_valid = 1'b1;
        wait_accept();
        @(negedge mclk);
        hba_data_in_valid = 1'b0;
        cnt = 0;
        while (done_cnt == start && cnt < TIMEOUT) begin
            @(negedge mclk);
            cnt++;
        end
        assert (done_cnt != start) else begin
            $display("timeout, get_fis_done never pulsed");
            errors++;
        end
    endtask

    task automatic pulse_status_cmd(input int kind);
        predict_status_cmd(kind);
        @(negedge mclk);
        update_err_sts    = kind == 0;
        clear_bsy_drq     = kind == 1;
        clear_bsy_set_drq = kind == 2;
        set_bsy           = kind == 3;
        @(negedge mclk);
        {update_err_sts, clear_bsy_drq, clear_bsy_set_drq, set_bsy} = 4'b0000;
    endtask

    task automatic check_writes();
        int cnt;
        cnt = 0;
        while (seen_addr.size() < exp_addr.size() && cnt < TIMEOUT) begin
            @(negedge mclk);
            cnt++;
        end
        repeat (3) @(negedge mclk);  // catch any late extra write
        check_value("reg_we count", seen_addr.size(), exp_addr.size());
        for (int i = 0; i < exp_addr.size() && i < seen_addr.size(); i++) begin
            check_value("reg_addr", seen_addr[i], exp_addr[i]);
            check_value("reg_data", seen_data[i], exp_data[i]);
        end
        seen_addr.delete();
        seen_data.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic check_tfd();
        check_value("tfd_sts", tfd_sts, m_sts);
        check_value("tfd_err", tfd_err, m_err);
    endtask

    task automatic apply_reset();
        hba_rst = 1'b1;
        repeat (16) @(negedge mclk);
        hba_rst = 1'b0;
        clear_model();
        seen_addr.delete();
        seen_data.delete();
        dma_seen.delete();
    endtask

    task automatic end_test(input string name, input int errs);
        tests_run++;
        if (errors == errs) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errs);
        end
    endtask

    initial begin
        int       errs;
        fis_cmd_e cmd;
        hba_data_in       = 32'h0;
        hba_data_in_type  = WT_DATA;
        hba_data_in_valid = 1'b0;
        fis_cmd           = FIS_IGNORE;
        fis_cmd_valid     = 1'b0;
        pcmd_fre          = 1'b0;
        {update_err_sts, clear_bsy_drq, clear_bsy_set_drq, set_bsy} = 4'b0000;
        dma_in_ready      = 1'b1;
        dma_rand          = 1'b0;
        end_gap           = 0;
        end_busy          = 1'b0;
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        done_cnt          = 0;
        apply_reset();

        errs = errors;  // outputs after reset and head detection
        check_value("busy/done/ok/err/ferr/reg_we/dma_in_valid/fis_first_vld",
                    {get_fis_busy, get_fis_done, fis_ok, fis_err, fis_ferr, reg_we,
                     dma_in_valid, fis_first_vld}, 0);
        check_value("tfd_err/tfd_sts", {tfd_err, tfd_sts}, 0);
        hba_data_in_type  = WT_HEAD;
        hba_data_in_valid = 1'b1;
        for (int cnt = 0; cnt < TIMEOUT && !fis_first_vld; cnt++)
            @(posedge mclk);
        assert (fis_first_vld) else begin
            $display("timeout, fis_first_vld did not rise for an idle head");
            errors++;
        end
        @(negedge mclk);
        hba_data_in_valid = 1'b0;
        end_test("reset state and fis_first_vld", errs);

        errs = errors;
        for (int n = 0; n < 12; n++) begin
            cmd = stored_kinds[rand_below(5)];
            make_body(1 + rand_below(stored_len(cmd)));
            run_fis(cmd, 1'b1, WT_OK);
            check_value("fis_ok", done_ok, 1);
            check_value("fis_err", done_err, 0);
            check_writes();
            check_tfd();
        end
        end_test("stored fis writes", errs);

        errs = errors;  // pcmd_fre low with a bad crc end
        for (int n = 0; n < 6; n++) begin
            cmd = stored_kinds[rand_below(5)];
            make_body(1 + rand_below(stored_len(cmd)));
            run_fis(cmd, 1'b0, WT_ERR);
            check_value("fis_err", done_err, 1);
            check_value("fis_ok", done_ok, 0);
            check_writes();
            check_tfd();
        end
        end_test("store disabled and error end", errs);

        errs = errors;
        for (int n = 0; n < 6; n++) begin
            cmd = n % 3 == 0 ? FIS_RFIS : (n % 3 == 1 ? FIS_SDBFIS : FIS_PSFIS);
            make_body(1 + rand_below(stored_len(cmd)));
            run_fis(cmd, 1'b1, WT_OK);
            repeat (6) pulse_status_cmd(rand_below(4));
            check_writes();
            check_tfd();
        end
        end_test("pxtfd tracking and write back", errs);

        errs = errors;
        for (int n = 0; n < 4; n++) begin
            make_body(2 + rand_below(40));  // header plus at least one payload word
            dma_seen.delete();
            dma_rand = 1'b1;
            run_fis(FIS_DATA, 1'b1, WT_OK);
            dma_rand     = 1'b0;
            dma_in_ready = 1'b1;
            check_value("dma_in_valid count", dma_seen.size(), body_words.size() - 1);
            for (int i = 0; i < dma_seen.size() && i + 1 < body_words.size(); i++)
                check_value("hba_data_in at dma_in_valid", dma_seen[i], body_words[i + 1]);
            check_value("data_in_dwords", data_in_dwords, body_words.size() - 1);
            check_value("fis_ok", done_ok, 1);
            check_writes();
        end
        end_test("data fis forwarding", errs);

        errs = errors;  // two words past the stored length
        make_body(stored_len(FIS_RFIS) + 2);
        end_gap = 3;  // end word comes late so only the fatal can end busy
        run_fis(FIS_RFIS, 1'b1, WT_OK);
        end_gap = 0;
        check_value("fis_ferr", fis_ferr, 1);
        check_value("get_fis_busy at end word", end_busy, 0);
        check_writes();
        check_tfd();
        check_value("fis_ferr", fis_ferr, 1);  // sticky
        apply_reset();
        check_value("fis_ferr", fis_ferr, 0);
        end_test("too-long fatal", errs);

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule
